//--- logic/rdp_geom_pkg.sv
/*
 * Read datapath bus geometry
 * Describes how the half-rate AFI bus is built from DQ beats and groups.
 * The group count and width here are only the top-level defaults.
 */

`default_nettype none

package rdp_geom_pkg;

	// Memory clock cycles per AFI clock cycle at half rate
	localparam int AFI_RATE_RATIO = 2;

	// DDR gives two DQ beats per memory cycle, so four slots per AFI cycle
	localparam int NUM_TIME_SLOTS = 2 * AFI_RATE_RATIO;

	// The default interface has two DQS groups of eight DQ pins each
	localparam int DEF_NUM_DQS_GROUPS = 2;
	localparam int DEF_DQ_GROUP_WIDTH = 8;

endpackage

`default_nettype wire

//--- logic/rdp_timing_pkg.sv
/*
 * Read datapath timing constants
 * Holds the latency counter width, the read FIFO depth and the
 * functions that place the on-die termination window around a read.
 */

`default_nettype none

package rdp_timing_pkg;

	// Width of the sequencer's read latency setting
	localparam int LATENCY_WIDTH = 5;

	// Depth of the request shifter, one tap per AFI cycle of latency
	localparam int DEF_MAX_READ_LATENCY = 16;

	// Memory read latency in memory clock cycles
	localparam int DEF_MEM_T_RL = 11;

	// Read FIFO depth must stay a power of two so the pointers wrap freely
	localparam int READ_FIFO_DEPTH = 8;
	localparam int READ_FIFO_ADDR_WIDTH = $clog2(READ_FIFO_DEPTH);

	// AFI cycles from a read request until termination must be released
	function automatic int oct_on_delay(input int t_rl);
		return (t_rl > 4) ? (t_rl - 4) / 2 : 0;
	endfunction

	// AFI cycles from a read request until termination may return
	function automatic int oct_off_delay(input int t_rl);
		return (t_rl + 6) / 2;
	endfunction

endpackage

`default_nettype wire

//--- logic/read_return_if.sv
/*
 * Read return interface
 * Carries the common pop strobe from the latency shifter to every
 * group FIFO, and the popped heads on to the output mapper.
 */

`default_nettype none

interface read_return_if #(
	parameter int NUM_DQS_GROUPS = rdp_geom_pkg::DEF_NUM_DQS_GROUPS,
	parameter int DQ_GROUP_WIDTH = rdp_geom_pkg::DEF_DQ_GROUP_WIDTH
) ();

	// One pop pulse pops all groups in the same cycle
	logic rd_en;
	// Head entry of each group FIFO, valid combinationally
	logic [rdp_geom_pkg::NUM_TIME_SLOTS*DQ_GROUP_WIDTH-1:0] rd_data [NUM_DQS_GROUPS];
	logic [NUM_DQS_GROUPS-1:0] rd_empty;
	// Copy of the pop that qualifies the registered output data
	logic rd_fire;

	modport source_mp (output rd_en, output rd_fire);
	modport fifo_mp (input rd_en, output rd_data, output rd_empty);
	modport sink_mp (input rd_fire, input rd_data);

endinterface

`default_nettype wire

//--- logic/read_capture.sv
/*
 * Read capture stage
 * Cuts the DDIO read bus into per-group beats and registers each beat
 * with its write strobe. The sequencer's FIFO reset is registered as
 * well, so that a clear reaches the FIFO on the same cycle as writes.
 */

`default_nettype none

module read_capture #(
	parameter int NUM_DQS_GROUPS = rdp_geom_pkg::DEF_NUM_DQS_GROUPS,
	parameter int DQ_GROUP_WIDTH = rdp_geom_pkg::DEF_DQ_GROUP_WIDTH
) (
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic [NUM_DQS_GROUPS*rdp_geom_pkg::NUM_TIME_SLOTS*DQ_GROUP_WIDTH-1:0] ddio_phy_dq_i,
	input  logic [NUM_DQS_GROUPS-1:0] capture_valid_i,
	input  logic [NUM_DQS_GROUPS-1:0] seq_read_fifo_reset_i,
	output logic [NUM_DQS_GROUPS-1:0] wr_en_o,
	output logic [rdp_geom_pkg::NUM_TIME_SLOTS*DQ_GROUP_WIDTH-1:0] wr_data_o [NUM_DQS_GROUPS],
	output logic [NUM_DQS_GROUPS-1:0] fifo_clear_o
);

	// One group's beat holds all four time slots, slot 0 lowest
	localparam int BEAT_WIDTH = rdp_geom_pkg::NUM_TIME_SLOTS * DQ_GROUP_WIDTH;

	// Strobes and clears reach the FIFO bank one cycle after the inputs
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_en_o <= '0;
			fifo_clear_o <= '0;
		end
		else
		begin
			wr_en_o <= capture_valid_i;
			fifo_clear_o <= seq_read_fifo_reset_i;
		end
	end

	// The DDIO bus is ordered by group first, so each slice is contiguous
	always_ff @(posedge pll_afi_clk)
	begin
		for (int g = 0; g < NUM_DQS_GROUPS; g++)
		begin
			wr_data_o[g] <= ddio_phy_dq_i[g*BEAT_WIDTH +: BEAT_WIDTH];
		end
	end

	// A beat that lands in a FIFO while it is being cleared would be lost
	a_no_write_in_clear: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(wr_en_o & fifo_clear_o) == '0)
	else $error("read_capture: write strobe during FIFO clear");

endmodule

`default_nettype wire

//--- logic/read_fifo_bank.sv
/*
 * Read FIFO bank
 * One flop-array FIFO per DQS group. Writes come from the capture
 * stage, and a single pop from the latency shifter drains all groups
 * together. Heads and empty flags are shown combinationally.
 */

`default_nettype none

module read_fifo_bank #(
	parameter int NUM_DQS_GROUPS = rdp_geom_pkg::DEF_NUM_DQS_GROUPS,
	parameter int DQ_GROUP_WIDTH = rdp_geom_pkg::DEF_DQ_GROUP_WIDTH
) (
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic [NUM_DQS_GROUPS-1:0] wr_en_i,
	input  logic [rdp_geom_pkg::NUM_TIME_SLOTS*DQ_GROUP_WIDTH-1:0] wr_data_i [NUM_DQS_GROUPS],
	input  logic [NUM_DQS_GROUPS-1:0] fifo_clear_i,
	read_return_if.fifo_mp rdr
);

	localparam int BEAT_WIDTH = rdp_geom_pkg::NUM_TIME_SLOTS * DQ_GROUP_WIDTH;
	localparam int DEPTH = rdp_timing_pkg::READ_FIFO_DEPTH;
	localparam int AW = rdp_timing_pkg::READ_FIFO_ADDR_WIDTH;

	for (genvar g = 0; g < NUM_DQS_GROUPS; g++)
	begin : g_fifo
		logic [BEAT_WIDTH-1:0] mem [DEPTH];
		logic [AW-1:0] wr_ptr;
		logic [AW-1:0] rd_ptr;
		// One extra bit so that a full FIFO is told apart from an empty one
		logic [AW:0] count;

		// Pointers wrap on their own because the depth is a power of two
		always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
		begin
			if (!reset_n_afi_clk)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end
			else if (fifo_clear_i[g])
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end
			else
			begin
				if (wr_en_i[g])
					wr_ptr <= wr_ptr + 1'b1;
				if (rdr.rd_en)
					rd_ptr <= rd_ptr + 1'b1;
				count <= count + (AW+1)'(wr_en_i[g]) - (AW+1)'(rdr.rd_en);
			end
		end

		always_ff @(posedge pll_afi_clk)
		begin
			if (wr_en_i[g])
				mem[wr_ptr] <= wr_data_i[g];
		end

		assign rdr.rd_data[g] = mem[rd_ptr];
		assign rdr.rd_empty[g] = (count == '0);

		// The shifter pops on a fixed latency, so data must already be here
		a_no_underflow: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
			rdr.rd_en |-> !rdr.rd_empty[g])
		else $error("read_fifo_bank: pop on empty FIFO %0d", g);

		a_no_overflow: assert property (@(posedge pll_afi_clk)
			disable iff (!reset_n_afi_clk || fifo_clear_i[g])
			(wr_en_i[g] && !rdr.rd_en) |-> (count != DEPTH))
		else $error("read_fifo_bank: write to full FIFO %0d", g);
	end

endmodule

`default_nettype wire

//--- logic/read_latency_shifter.sv
/*
 * Read latency shifter
 * Delays the controller's read request by the latency that the
 * sequencer calibrated, then pops all group FIFOs at once. Several
 * requests may travel down the shifter at the same time.
 */

`default_nettype none

module read_latency_shifter #(
	parameter int MAX_READ_LATENCY = rdp_timing_pkg::DEF_MAX_READ_LATENCY
) (
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic afi_rdata_en_full_i,
	input  logic [rdp_timing_pkg::LATENCY_WIDTH-1:0] seq_read_latency_i,
	read_return_if.source_mp rdr
);

	// Bit i holds the request made i+1 cycles ago
	logic [MAX_READ_LATENCY-1:0] req_shift_q;
	logic tap_hit;

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			req_shift_q <= '0;
		else
			req_shift_q <= {req_shift_q[MAX_READ_LATENCY-2:0], afi_rdata_en_full_i};
	end

	// A latency of L selects the request issued L cycles before this one
	always_comb
	begin
		tap_hit = 1'b0;
		for (int i = 0; i < MAX_READ_LATENCY; i++)
		begin
			if (seq_read_latency_i == rdp_timing_pkg::LATENCY_WIDTH'(i + 1))
				tap_hit = req_shift_q[i];
		end
	end

	assign rdr.rd_en = tap_hit;
	assign rdr.rd_fire = tap_hit;

	// A request must always find a tap that it can come out of
	a_latency_range: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_en_full_i |->
		(seq_read_latency_i != '0 && int'(seq_read_latency_i) < MAX_READ_LATENCY))
	else $error("read_latency_shifter: latency %0d out of range", seq_read_latency_i);

endmodule

`default_nettype wire

//--- logic/rdata_mapper.sv
/*
 * Read data mapper
 * Registers the popped beats of all groups and drives them in two
 * orders: the AFI bus by time slot then group, and the sequencer bus
 * by group then time slot.
 */

`default_nettype none

module rdata_mapper #(
	parameter int NUM_DQS_GROUPS = rdp_geom_pkg::DEF_NUM_DQS_GROUPS,
	parameter int DQ_GROUP_WIDTH = rdp_geom_pkg::DEF_DQ_GROUP_WIDTH
) (
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	read_return_if.sink_mp rdr,
	output logic [NUM_DQS_GROUPS*rdp_geom_pkg::NUM_TIME_SLOTS*DQ_GROUP_WIDTH-1:0] afi_rdata_o,
	output logic [NUM_DQS_GROUPS*rdp_geom_pkg::NUM_TIME_SLOTS*DQ_GROUP_WIDTH-1:0]
		phy_mux_read_fifo_q_o,
	output logic afi_rdata_valid_o
);

	localparam int SLOTS = rdp_geom_pkg::NUM_TIME_SLOTS;
	localparam int BEAT_WIDTH = SLOTS * DQ_GROUP_WIDTH;
	// Width of one time slot across all groups on the AFI bus
	localparam int SLOT_WIDTH = NUM_DQS_GROUPS * DQ_GROUP_WIDTH;

	logic [BEAT_WIDTH-1:0] beat_q [NUM_DQS_GROUPS];

	// Data holds between pops, while valid only follows the pop itself
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			afi_rdata_valid_o <= 1'b0;
			for (int g = 0; g < NUM_DQS_GROUPS; g++)
				beat_q[g] <= '0;
		end
		else
		begin
			afi_rdata_valid_o <= rdr.rd_fire;
			if (rdr.rd_fire)
			begin
				for (int g = 0; g < NUM_DQS_GROUPS; g++)
					beat_q[g] <= rdr.rd_data[g];
			end
		end
	end

	// ******************************************************************
	// Slot reordering
	// ******************************************************************
	for (genvar g = 0; g < NUM_DQS_GROUPS; g++)
	begin : g_group
		for (genvar t = 0; t < SLOTS; t++)
		begin : g_slot
			// AFI places all groups of one slot next to each other
			assign afi_rdata_o[t*SLOT_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				beat_q[g][t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
			// The sequencer keeps each group's slots together, as captured
			assign phy_mux_read_fifo_q_o[g*BEAT_WIDTH + t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				beat_q[g][t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
		end
	end

endmodule

`default_nettype wire

//--- logic/oct_control.sv
/*
 * On-die termination control
 * Keeps a short history of read requests and forces termination off
 * outside the window in which read data returns from the memory.
 */

`default_nettype none

module oct_control #(
	parameter int MEM_T_RL = rdp_timing_pkg::DEF_MEM_T_RL
) (
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic afi_rdata_en_full_i,
	output logic force_oct_off_o
);

	// Window edges in AFI cycles after the request
	localparam int OCT_ON = rdp_timing_pkg::oct_on_delay(MEM_T_RL);
	localparam int OCT_OFF = rdp_timing_pkg::oct_off_delay(MEM_T_RL);

	logic [OCT_OFF-1:0] req_hist_q;
	// Tap k is the request made k cycles ago, tap 0 the current one
	logic [OCT_OFF:0] req_taps;

	assign req_taps = {req_hist_q, afi_rdata_en_full_i};

	// Termination stays on while any request sits between the two edges
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			req_hist_q <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			req_hist_q <= req_taps[OCT_OFF-1:0];
			force_oct_off_o <= ~(|req_taps[OCT_OFF:OCT_ON]);
		end
	end

endmodule

`default_nettype wire

//--- logic/read_datapath.sv
/*
 * DDR PHY read datapath, single AFI clock domain at half rate
 * Captures read beats per DQS group into FIFOs, pops them after the
 * calibrated latency, and returns them in AFI and sequencer order.
 */

`default_nettype none

module read_datapath #(
	parameter int NUM_DQS_GROUPS = rdp_geom_pkg::DEF_NUM_DQS_GROUPS,
	parameter int DQ_GROUP_WIDTH = rdp_geom_pkg::DEF_DQ_GROUP_WIDTH,
	parameter int MAX_READ_LATENCY = rdp_timing_pkg::DEF_MAX_READ_LATENCY,
	parameter int MEM_T_RL = rdp_timing_pkg::DEF_MEM_T_RL
) (
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic [NUM_DQS_GROUPS*rdp_geom_pkg::NUM_TIME_SLOTS*DQ_GROUP_WIDTH-1:0] ddio_phy_dq_i,
	input  logic [NUM_DQS_GROUPS-1:0] capture_valid_i,
	input  logic [NUM_DQS_GROUPS-1:0] seq_read_fifo_reset_i,
	input  logic [rdp_timing_pkg::LATENCY_WIDTH-1:0] seq_read_latency_i,
	input  logic afi_rdata_en_full_i,
	output logic [NUM_DQS_GROUPS*rdp_geom_pkg::NUM_TIME_SLOTS*DQ_GROUP_WIDTH-1:0] afi_rdata_o,
	output logic [NUM_DQS_GROUPS*rdp_geom_pkg::NUM_TIME_SLOTS*DQ_GROUP_WIDTH-1:0]
		phy_mux_read_fifo_q_o,
	output logic afi_rdata_valid_o,
	output logic force_oct_off_o
);

	// Capture side to FIFO bank
	logic [NUM_DQS_GROUPS-1:0] cap_wr_en;
	logic [rdp_geom_pkg::NUM_TIME_SLOTS*DQ_GROUP_WIDTH-1:0] cap_wr_data [NUM_DQS_GROUPS];
	logic [NUM_DQS_GROUPS-1:0] cap_clear;

	read_return_if #(.NUM_DQS_GROUPS(NUM_DQS_GROUPS), .DQ_GROUP_WIDTH(DQ_GROUP_WIDTH)) rdr ();

	read_capture #(.NUM_DQS_GROUPS(NUM_DQS_GROUPS), .DQ_GROUP_WIDTH(DQ_GROUP_WIDTH)) u_capture (
		.pll_afi_clk(pll_afi_clk), .reset_n_afi_clk(reset_n_afi_clk),
		.ddio_phy_dq_i(ddio_phy_dq_i), .capture_valid_i(capture_valid_i),
		.seq_read_fifo_reset_i(seq_read_fifo_reset_i), .wr_en_o(cap_wr_en),
		.wr_data_o(cap_wr_data), .fifo_clear_o(cap_clear));

	read_fifo_bank #(.NUM_DQS_GROUPS(NUM_DQS_GROUPS), .DQ_GROUP_WIDTH(DQ_GROUP_WIDTH)) u_fifos (
		.pll_afi_clk(pll_afi_clk), .reset_n_afi_clk(reset_n_afi_clk), .wr_en_i(cap_wr_en),
		.wr_data_i(cap_wr_data), .fifo_clear_i(cap_clear), .rdr(rdr));

	read_latency_shifter #(.MAX_READ_LATENCY(MAX_READ_LATENCY)) u_shifter (
		.pll_afi_clk(pll_afi_clk), .reset_n_afi_clk(reset_n_afi_clk),
		.afi_rdata_en_full_i(afi_rdata_en_full_i), .seq_read_latency_i(seq_read_latency_i),
		.rdr(rdr));

	rdata_mapper #(.NUM_DQS_GROUPS(NUM_DQS_GROUPS), .DQ_GROUP_WIDTH(DQ_GROUP_WIDTH)) u_mapper (
		.pll_afi_clk(pll_afi_clk), .reset_n_afi_clk(reset_n_afi_clk), .rdr(rdr),
		.afi_rdata_o(afi_rdata_o), .phy_mux_read_fifo_q_o(phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o(afi_rdata_valid_o));

	// Termination follows the request directly, not the popped data
	oct_control #(.MEM_T_RL(MEM_T_RL)) u_oct (
		.pll_afi_clk(pll_afi_clk), .reset_n_afi_clk(reset_n_afi_clk),
		.afi_rdata_en_full_i(afi_rdata_en_full_i), .force_oct_off_o(force_oct_off_o));

endmodule

`default_nettype wire

//--- tests/tb_ref_model.svh
/*
 * Reference model for the read datapath testbench
 * Slot reordering for the AFI and sequencer buses, the OCT window
 * rule, and the Galois LFSR that makes the data beats.
 */

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

	// OCT window edges in AFI cycles for a memory read latency of 11
	localparam int OCT_ON_CYCLES = 3;
	localparam int OCT_OFF_CYCLES = 8;
	// Feedback mask of a 32-bit maximal-length polynomial
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	// One Galois step, shifting right and folding the taps back in
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	// AFI bus puts slot t of group g at t * (all groups) + g * (one group)
	function automatic logic [BUS-1:0] afi_order_of(input logic [BW-1:0] beats [NG]);
		logic [BUS-1:0] word;
		word = '0;
		for (int g = 0; g < NG; g++)
		begin
			for (int t = 0; t < SLOTS; t++)
				word[t*NG*GW + g*GW +: GW] = beats[g][t*GW +: GW];
		end
		return word;
	endfunction

	// Sequencer bus keeps all slots of one group together
	function automatic logic [BUS-1:0] seq_order_of(input logic [BW-1:0] beats [NG]);
		logic [BUS-1:0] word;
		word = '0;
		for (int g = 0; g < NG; g++)
		begin
			for (int t = 0; t < SLOTS; t++)
				word[g*SLOTS*GW + t*GW +: GW] = beats[g][t*GW +: GW];
		end
		return word;
	endfunction

	// Taps[k] is the request k cycles before the cycle that the output follows
	function automatic logic oct_off_expected(input logic [OCT_OFF_CYCLES:0] taps);
		logic hit;
		hit = 1'b0;
		for (int k = OCT_ON_CYCLES; k <= OCT_OFF_CYCLES; k++)
			hit = hit | taps[k];
		return !hit;
	endfunction

`endif

//--- tests/tb_read_datapath.sv
/*
 * Testbench for the DDR PHY read datapath
 * Captures LFSR beats into the group FIFOs, issues read requests at
 * several latencies, and checks valid timing, both output orders,
 * the FIFO clear and the OCT window against a cycle-level model.
 */

`default_nettype none

module tb_read_datapath;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int NG = rdp_geom_pkg::DEF_NUM_DQS_GROUPS;
	localparam int GW = rdp_geom_pkg::DEF_DQ_GROUP_WIDTH;
	localparam int SLOTS = rdp_geom_pkg::NUM_TIME_SLOTS;
	localparam int BW = SLOTS * GW;
	localparam int BUS = NG * BW;
	localparam int MAX_LAT = rdp_timing_pkg::DEF_MAX_READ_LATENCY;
	localparam int LW = rdp_timing_pkg::LATENCY_WIDTH;
	localparam int HIST_DEPTH = 1024;
	localparam int NUM_TESTS = 6;

	`include "tb_ref_model.svh"

	// ******************************************************************
	// Stimulus table, one column per array
	// ******************************************************************
	// Name, latency, beats per group, requests, gap after each request, clear
	string test_name [NUM_TESTS] = '{"lat1_single", "lat5_gap", "lat15_b2b",
		"clear_lat3", "lat8_b2b", "clear_flush"};
	int test_lat [NUM_TESTS] = '{1, 5, 15, 3, 8, 2};
	int test_beats [NUM_TESTS] = '{2, 4, 6, 3, 5, 4};
	int test_reqs [NUM_TESTS] = '{2, 3, 6, 2, 6, 4};
	int test_gap [NUM_TESTS] = '{0, 2, 0, 1, 0, 0};
	bit test_clr [NUM_TESTS] = '{0, 0, 0, 1, 0, 1};

	logic pll_afi_clk = 1'b0;
	logic reset_n_afi_clk;
	logic [BUS-1:0] ddio_phy_dq_i;
	logic [NG-1:0] capture_valid_i;
	logic [NG-1:0] seq_read_fifo_reset_i;
	logic [LW-1:0] seq_read_latency_i;
	logic afi_rdata_en_full_i;
	logic [BUS-1:0] afi_rdata_o;
	logic [BUS-1:0] phy_mux_read_fifo_q_o;
	logic afi_rdata_valid_o;
	logic force_oct_off_o;

	// Request history by cycle and the beats still expected from each FIFO
	logic [31:0] lfsr_state = 32'd81055;
	logic req_hist [HIST_DEPTH];
	logic [BW-1:0] exp_beats [NG][$];
	// Output data holds the last popped beats between pops
	logic [BW-1:0] last_beats [NG];
	int cyc;
	int cur_lat;
	string cur_name;
	int seen_valid;
	int checks;
	int errs;

	always #(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;

	read_datapath dut0 (
		.pll_afi_clk(pll_afi_clk), .reset_n_afi_clk(reset_n_afi_clk),
		.ddio_phy_dq_i(ddio_phy_dq_i), .capture_valid_i(capture_valid_i),
		.seq_read_fifo_reset_i(seq_read_fifo_reset_i), .seq_read_latency_i(seq_read_latency_i),
		.afi_rdata_en_full_i(afi_rdata_en_full_i), .afi_rdata_o(afi_rdata_o),
		.phy_mux_read_fifo_q_o(phy_mux_read_fifo_q_o), .afi_rdata_valid_o(afi_rdata_valid_o),
		.force_oct_off_o(force_oct_off_o));

	// Cycles before the first one after reset count as idle
	function automatic logic req_at(input int idx);
		if (idx < 0 || idx >= HIST_DEPTH)
			return 1'b0;
		return req_hist[idx];
	endfunction

	task automatic check_value(input string what, input logic [BUS-1:0] expected,
		input logic [BUS-1:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errs++;
			$display("ERR %s cycle %0d: expected %h actual %h", what, cyc, expected, actual);
		end
	endtask

	task automatic take_beat(output logic [BW-1:0] beat);
		for (int i = 0; i < BW; i++)
		begin
			beat[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// ******************************************************************
	// Each AFI cycle checks what the DUT shows and then drives the next inputs
	// ******************************************************************
	task automatic run_cycle(input logic req, input logic cap, input logic clr);
		logic [BW-1:0] beat;
		logic [OCT_OFF_CYCLES:0] taps;
		logic exp_valid;
		@(negedge pll_afi_clk);
		// A request in cycle n pops in n+L and shows up registered in n+L+1
		exp_valid = req_at(cyc - cur_lat - 1);
		check_value({cur_name, "/valid"}, BUS'(exp_valid), BUS'(afi_rdata_valid_o));
		if (exp_valid)
		begin
			for (int g = 0; g < NG; g++)
			begin
				if (exp_beats[g].size() == 0)
				begin
					errs++;
					$display("Test %s pops group %0d but no beat is left for it", cur_name, g);
				end
				else
					last_beats[g] = exp_beats[g].pop_front();
			end
		end
		check_value({cur_name, "/afi_rdata"}, afi_order_of(last_beats), afi_rdata_o);
		check_value({cur_name, "/seq_rdata"}, seq_order_of(last_beats), phy_mux_read_fifo_q_o);
		// Output in cycle m+1 follows the requests of cycles m-OFF up to m-ON
		for (int j = 0; j <= OCT_OFF_CYCLES; j++)
			taps[j] = req_at(cyc - 1 - j);
		check_value({cur_name, "/force_oct_off"}, BUS'(oct_off_expected(taps)),
			BUS'(force_oct_off_o));
		if (afi_rdata_valid_o)
			seen_valid++;
		afi_rdata_en_full_i = req;
		seq_read_latency_i = LW'(cur_lat);
		seq_read_fifo_reset_i = {NG{clr}};
		capture_valid_i = {NG{cap}};
		// The clear drops every beat captured before it
		if (clr)
		begin
			for (int g = 0; g < NG; g++)
				exp_beats[g].delete();
		end
		if (cap)
		begin
			for (int g = 0; g < NG; g++)
			begin
				take_beat(beat);
				ddio_phy_dq_i[g*BW +: BW] = beat;
				exp_beats[g].push_back(beat);
			end
		end
		if (cyc < HIST_DEPTH)
			req_hist[cyc] = req;
		cyc++;
	endtask

	task automatic run_test(input int t);
		cur_name = test_name[t];
		cur_lat = test_lat[t];
		seen_valid = 0;
		if (test_clr[t])
		begin
			// These beats are captured only to be thrown away by the clear
			repeat (test_beats[t]) run_cycle(1'b0, 1'b1, 1'b0);
			run_cycle(1'b0, 1'b0, 1'b1);
		end
		repeat (test_beats[t]) run_cycle(1'b0, 1'b1, 1'b0);
		for (int r = 0; r < test_reqs[t]; r++)
		begin
			run_cycle(1'b1, 1'b0, 1'b0);
			repeat (test_gap[t]) run_cycle(1'b0, 1'b0, 1'b0);
		end
		// Drain the shifter so the next latency starts with nothing in flight
		repeat (MAX_LAT + 2) run_cycle(1'b0, 1'b0, 1'b0);
		check_value({cur_name, "/valid_count"}, BUS'(test_reqs[t]), BUS'(seen_valid));
	endtask

	function automatic int table_cycles();
		int total;
		total = RESET_CYCLES + 1;
		for (int t = 0; t < NUM_TESTS; t++)
			total += test_beats[t] * (test_clr[t] ? 2 : 1) + int'(test_clr[t])
				+ test_reqs[t] * (test_gap[t] + 1) + MAX_LAT + 2;
		return total;
	endfunction

	initial
	begin : watchdog
		int limit;
		limit = table_cycles() + 50;
		#(limit * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		reset_n_afi_clk = 1'b0;
		ddio_phy_dq_i = '0;
		capture_valid_i = '0;
		seq_read_fifo_reset_i = '0;
		seq_read_latency_i = LW'(1);
		afi_rdata_en_full_i = 1'b0;
		checks = 0;
		errs = 0;
		seen_valid = 0;
		cur_lat = 1;
		cur_name = "after_reset";
		cyc = 0;
		for (int g = 0; g < NG; g++)
			last_beats[g] = '0;
		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		// Still in reset, so every output must be at its reset value
		check_value("after_reset/valid", '0, BUS'(afi_rdata_valid_o));
		check_value("after_reset/force_oct_off", '0, BUS'(force_oct_off_o));
		check_value("after_reset/afi_rdata", '0, afi_rdata_o);
		check_value("after_reset/seq_rdata", '0, phy_mux_read_fifo_q_o);
		// Release on this falling edge, which counts as idle cycle 0
		reset_n_afi_clk = 1'b1;
		req_hist[0] = 1'b0;
		cyc = 1;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("Summary: %0d checks, %0d errors", checks, errs);
		if (errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+tests
logic/rdp_geom_pkg.sv
logic/rdp_timing_pkg.sv
logic/read_return_if.sv
logic/read_capture.sv
logic/read_fifo_bank.sv
logic/read_latency_shifter.sv
logic/rdata_mapper.sv
logic/oct_control.sv
logic/read_datapath.sv
tests/tb_read_datapath.sv

//--- Makefile
# Verilator build and run for the read datapath testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_read_datapath
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_TEXT)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
